// File: compile.f
verilog/cpu_pkg.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_datapath.sv
verilog/cpu.sv
testbench/tb_cpu_assertions.sv
testbench/tb_checker.sv
testbench/tb_cpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_cpu -f compile.f -o tb_cpu_sim; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_cpu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: testbench/tb_cpu.sv
module tb_cpu
	import cpu_pkg::*;
();
	logic clk;
	logic reset;
	logic [addr_w-1:0] iread_addr;
	logic [inst_w-1:0] iread_data;
	logic [addr_w-1:0] dread_addr;
	logic [data_w-1:0] dread_data;
	logic [addr_w-1:0] dwrite_addr;
	logic [data_w-1:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;
	int check_errors;

	logic [7:0] imem [65536];
	logic [7:0] dmem [65536];

	// three prologue slots, sixty random ones and a closing TRAP
	opcode_t s_op [64];
	logic [15:0] s_arg [64];
	logic [15:0] s_addr [65];
	int s_len [64];

	logic [31:0] seed;
	logic [31:0] r;
	int i;
	int j;
	int span;
	int incw_count;
	int cycles;
	int timeouts;
	int total;

	cpu u_dut (
		.clk        (clk),
		.reset      (reset),
		.iread_addr (iread_addr),
		.iread_data (iread_data),
		.dread_addr (dread_addr),
		.dread_data (dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en  (dwrite_en),
		.trap       (trap)
	);

	tb_checker u_check (
		.clk        (clk),
		.reset      (reset),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en  (dwrite_en),
		.trap       (trap),
		.errors     (check_errors)
	);

	always #4 clk = ~clk;

	// synchronous memories with a write-first data side
	always @(posedge clk)
	begin
		if (dwrite_en[0])
			dmem[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] = dwrite_data[15:8];
		dread_data <= {dmem[dread_addr + 16'd1], dmem[dread_addr]};
		iread_data <= {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};
	end

	function automatic opcode_t pick_op(input logic [31:0] v);
		opcode_t ops [24];
		// stores listed twice so results show up often
		ops = '{op_nop, op_ld_xl_imm, op_add_xl_imm, op_sub_xl_imm, op_and_xl_imm,
			op_or_xl_imm, op_xor_xl_imm, op_add_xl_dir, op_ld_xl_yrel, op_inc_xl,
			op_ld_xh_xl, op_ldw_y_imm, op_ldw_z_y, op_incw_y, op_ld_dir_xl, op_ldw_dir_x,
			op_ldw_dir_y, op_jp, op_jrz, op_jrnz, op_jrc, op_jrnc, op_ld_dir_xl, op_ldw_dir_x};
		return ops[v[15:0] % 24];
	endfunction

	task automatic put_byte(input logic [15:0] a, input logic [7:0] v);
		imem[a] = v;
		u_check.imem_model[a] = v;
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;
		seed = 32'h6241a8da;
		incw_count = 0;
		timeouts = 0;

		for (i = 0; i < 65536; i++)
		begin
			r = $random(seed);
			dmem[i] = r[7:0];
			u_check.dmem_model[i] = r[7:0];
			put_byte(i[15:0], i[7:0] ^ i[15:8]);
		end

		s_op[0] = op_ld_xl_imm;
		s_op[1] = op_ld_xh_xl;
		s_op[2] = op_ldw_y_imm;
		for (i = 3; i < 63; i++)
		begin
			r = $random(seed);
			s_op[i] = pick_op(r);
			// few enough incw to keep y+d inside the window
			if (s_op[i] == op_incw_y)
			begin
				if (incw_count == 16)
					s_op[i] = op_inc_xl;
				else
					incw_count++;
			end
			if (i == 62 && s_op[i] inside {op_jp, op_jrz, op_jrnz, op_jrc, op_jrnc})
				s_op[i] = op_nop;
		end
		s_op[63] = op_trap;

		// operands and layout inside the 16'h0200 to 16'h02ff data window
		s_addr[0] = reset_vector;
		for (i = 0; i < 64; i++)
		begin
			r = $random(seed);
			s_arg[i] = 16'h0000;
			case (s_op[i])
				op_add_xl_dir, op_ld_dir_xl, op_ldw_dir_x, op_ldw_dir_y, op_ldw_y_imm:
				begin
					s_arg[i] = 16'h0200 + {10'h000, r[5:0]};
					s_len[i] = 3;
				end
				op_jp:
					s_len[i] = 3;
				op_nop, op_trap, op_inc_xl, op_ld_xh_xl, op_ldw_z_y, op_incw_y:
					s_len[i] = 1;
				op_ld_xl_yrel:
				begin
					s_arg[i] = {10'h000, r[5:0]};
					s_len[i] = 2;
				end
				default:
				begin
					s_arg[i] = {8'h00, r[7:0]};
					s_len[i] = 2;
				end
			endcase
			s_addr[i + 1] = s_addr[i] + s_len[i][15:0];
		end

		// forward targets on a slot boundary before the TRAP
		for (i = 3; i < 63; i++)
		begin
			if (s_op[i] inside {op_jp, op_jrz, op_jrnz, op_jrc, op_jrnc})
			begin
				r = $random(seed);
				span = (62 - i < 10) ? 62 - i : 10;
				j = i + 1 + int'(r[15:0]) % span;
				if (s_op[i] == op_jp)
					s_arg[i] = s_addr[j];
				else
					s_arg[i] = s_addr[j] - s_addr[i];
			end
		end

		for (i = 0; i < 64; i++)
		begin
			put_byte(s_addr[i], s_op[i]);
			if (s_len[i] > 1)
				put_byte(s_addr[i] + 16'd1, s_arg[i][7:0]);
			if (s_len[i] > 2)
				put_byte(s_addr[i] + 16'd2, s_arg[i][15:8]);
		end

		repeat (16) @(posedge clk);
		reset <= 1'b0;

		cycles = 0;
		while (!trap && cycles < 2000)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!trap)
		begin
			$display("timeout: trap did not rise within 2000 cycles after reset");
			timeouts = 1;
		end

		// a few more edges so the trap pulse can end
		repeat (3) @(posedge clk);
		total = check_errors + timeouts + u_dut.u_assert.fail_count;
		$display("errors: %0d (checker %0d, timeout %0d, assertions %0d)", total,
			check_errors, timeouts, u_dut.u_assert.fail_count);
		if (total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: testbench/tb_checker.sv
module tb_checker
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [addr_w-1:0] dwrite_addr,
	input  logic [data_w-1:0] dwrite_data,
	input  logic [1:0]        dwrite_en,
	input  logic              trap,
	output int                errors
);
	// loaded by the testbench top before the clock starts
	logic [7:0] imem_model [65536];
	logic [7:0] dmem_model [65536];
	logic [15:0] m_pc;
	logic [15:0] m_x;
	logic [15:0] m_y;
	logic [15:0] m_z;
	logic m_c;
	logic m_zf;
	logic m_n;
	logic finished;

	initial
	begin
		errors = 0;
		finished = 1'b0;
		m_pc = reset_vector;
		m_x = 16'h0000;
		m_y = 16'h0000;
		m_z = 16'h0000;
		m_c = 1'b0;
		m_zf = 1'b0;
		m_n = 1'b0;
	end

	task automatic put_xl(input logic [7:0] v);
		m_x[7:0] = v;
		m_zf = (v == 8'h00);
		m_n = v[7];
	endtask

	task automatic word_flags(input logic [15:0] v);
		m_zf = (v == 16'h0000);
		m_n = v[15];
	endtask

	function automatic logic [15:0] model_next_pc(input logic [7:0] op, input logic [7:0] b1,
		input logic [15:0] w);
		logic taken;
		taken = (op == op_jrz && m_zf) || (op == op_jrnz && !m_zf) ||
			(op == op_jrc && m_c) || (op == op_jrnc && !m_c);
		if (op == op_jp)
			return w;
		// jr is relative to its own address
		if (taken)
			return m_pc + {{8{b1[7]}}, b1};
		case (op)
			op_ldw_y_imm, op_add_xl_dir, op_ld_dir_xl, op_ldw_dir_x, op_ldw_dir_y:
				return m_pc + 16'd3;
			op_ld_xl_imm, op_add_xl_imm, op_sub_xl_imm, op_and_xl_imm, op_or_xl_imm,
			op_xor_xl_imm, op_ld_xl_yrel, op_jrz, op_jrnz, op_jrc, op_jrnc:
				return m_pc + 16'd2;
			default:
				return m_pc + 16'd1;
		endcase
	endfunction

	// steps the model until it stores or sits on a TRAP
	task automatic run_model(output logic at_trap, output logic [15:0] st_addr,
		output logic [1:0] st_en, output logic [15:0] st_data);
		logic [7:0] op;
		logic [7:0] b1;
		logic [7:0] operand;
		logic [15:0] w;
		logic [8:0] sum;
		int steps;
		at_trap = 1'b0;
		st_addr = 16'h0000;
		st_en = 2'b00;
		st_data = 16'h0000;
		steps = 0;
		while (!at_trap && st_en == 2'b00 && steps < 256)
		begin
			op = imem_model[m_pc];
			b1 = imem_model[m_pc + 16'd1];
			w = {imem_model[m_pc + 16'd2], b1};
			steps = steps + 1;
			case (op)
				op_trap:
					at_trap = 1'b1;
				op_ld_xl_imm:
					put_xl(b1);
				op_add_xl_imm, op_add_xl_dir:
				begin
					operand = (op == op_add_xl_dir) ? dmem_model[w] : b1;
					sum = {1'b0, m_x[7:0]} + {1'b0, operand};
					m_c = sum[8];
					put_xl(sum[7:0]);
				end
				op_sub_xl_imm:
				begin
					m_c = (m_x[7:0] < b1);
					put_xl(m_x[7:0] - b1);
				end
				op_and_xl_imm:
					put_xl(m_x[7:0] & b1);
				op_or_xl_imm:
					put_xl(m_x[7:0] | b1);
				op_xor_xl_imm:
					put_xl(m_x[7:0] ^ b1);
				op_ld_xl_yrel:
					put_xl(dmem_model[m_y + {8'h00, b1}]);
				op_inc_xl:
				begin
					sum = {1'b0, m_x[7:0]} + 9'd1;
					m_c = sum[8];
					put_xl(sum[7:0]);
				end
				op_ld_xh_xl:
					m_x[15:8] = m_x[7:0];
				op_ldw_y_imm:
				begin
					m_y = w;
					word_flags(m_y);
				end
				op_ldw_z_y:
				begin
					m_z = m_y;
					word_flags(m_z);
				end
				op_incw_y:
				begin
					{m_c, m_y} = {1'b0, m_y} + 17'd1;
					word_flags(m_y);
				end
				op_ld_dir_xl:
				begin
					st_en = 2'b01;
					st_data = {8'h00, m_x[7:0]};
				end
				op_ldw_dir_x, op_ldw_dir_y:
				begin
					st_en = 2'b11;
					st_data = (op == op_ldw_dir_y) ? m_y : m_x;
				end
				default:
					st_en = 2'b00;
			endcase
			if (st_en != 2'b00)
			begin
				st_addr = w;
				dmem_model[w] = st_data[7:0];
				if (st_en[1])
					dmem_model[w + 16'd1] = st_data[15:8];
			end
			if (!at_trap)
				m_pc = model_next_pc(op, b1, w);
		end
	endtask

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_store();
		logic at_trap;
		logic [15:0] e_addr;
		logic [1:0] e_en;
		logic [15:0] e_data;
		run_model(at_trap, e_addr, e_en, e_data);
		if (at_trap)
		begin
			errors = errors + 1;
			$display("store at %0t to %h after the model reached TRAP", $time, dwrite_addr);
		end
		else if (e_en == 2'b00)
		begin
			errors = errors + 1;
			$display("model found no further store or TRAP at %0t", $time);
		end
		else
		begin
			compare_value("dwrite_addr", dwrite_addr, e_addr);
			compare_value("dwrite_en", {14'h0000, dwrite_en}, {14'h0000, e_en});
			// only the enabled bytes matter
			if (e_en[0])
				compare_value("dwrite_data[7:0]", {8'h00, dwrite_data[7:0]},
					{8'h00, e_data[7:0]});
			if (e_en[1])
				compare_value("dwrite_data[15:8]", {8'h00, dwrite_data[15:8]},
					{8'h00, e_data[15:8]});
		end
	endtask

	task automatic check_trap();
		logic at_trap;
		logic [15:0] e_addr;
		logic [1:0] e_en;
		logic [15:0] e_data;
		run_model(at_trap, e_addr, e_en, e_data);
		if (!at_trap)
		begin
			errors = errors + 1;
			$display("trap at %0t while the model still expects a store to %h", $time, e_addr);
		end
		finished = 1'b1;
	endtask

	always @(negedge clk)
	begin
		if (!reset && !finished)
		begin
			if (dwrite_en != 2'b00)
				check_store();
			if (trap)
				check_trap();
		end
	end

endmodule

// File: testbench/tb_cpu_assertions.sv
module tb_cpu_assertions
	import cpu_pkg::*;
(
	input logic              clk,
	input logic              reset,
	input logic [inst_w-1:0] iread_data,
	input logic [1:0]        dwrite_en,
	input logic              trap
);
	int fail_count = 0;

	quiet_in_reset: assert property (@(posedge clk) reset |-> (dwrite_en == 2'b00 && !trap))
		else
		begin
			fail_count++;
			$error("store or trap while reset is high");
		end

	known_store_enable: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(dwrite_en))
		else
		begin
			fail_count++;
			$error("dwrite_en is unknown");
		end

	// the opcode on iread_data is the next one to execute
	single_trap: assert property (@(posedge clk) disable iff (reset)
		(trap && iread_data[7:0] != op_trap) |=> !trap)
		else
		begin
			fail_count++;
			$error("trap stayed high after a single TRAP");
		end

endmodule

bind cpu tb_cpu_assertions u_assert (
	.clk       (clk),
	.reset     (reset),
	.iread_data(iread_data),
	.dwrite_en (dwrite_en),
	.trap      (trap)
);

// File: verilog/cpu.sv
module cpu
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	output logic [addr_w-1:0] iread_addr,
	input  logic [inst_w-1:0] iread_data,
	output logic [addr_w-1:0] dread_addr,
	input  logic [data_w-1:0] dread_data,
	output logic [addr_w-1:0] dwrite_addr,
	output logic [data_w-1:0] dwrite_data,
	output logic [1:0]        dwrite_en,
	output logic              trap
);
	logic [inst_w-1:0] inst;
	logic exec_valid;
	exec_ctrl_t ctrl;
	flags_t next_flags;
	logic [data_w-1:0] x;
	logic [data_w-1:0] y;
	logic [data_w-1:0] next_y;
	logic [1:0] wr_addr;
	logic [1:0] wr_en;
	logic [data_w-1:0] wr_data;

	cpu_fetch u_fetch (
		.clk       (clk),
		.reset     (reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.next_y    (next_y),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.inst      (inst),
		.exec_valid(exec_valid)
	);

	cpu_decode u_decode (
		.inst_opcode(opcode_t'(inst[7:0])),
		.exec_valid (exec_valid),
		.ctrl       (ctrl)
	);

	cpu_datapath u_datapath (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.inst       (inst),
		.x          (x),
		.y          (y),
		.dread_data (dread_data),
		.wr_addr    (wr_addr),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.next_flags (next_flags),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en  (dwrite_en),
		.trap       (trap)
	);

	cpu_regfile u_regfile (
		.clk    (clk),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (wr_en),
		.x      (x),
		.y      (y),
		.z      (),
		.next_y (next_y)
	);

endmodule

// File: verilog/cpu_datapath.sv
module cpu_datapath
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  exec_ctrl_t        ctrl,
	input  logic [inst_w-1:0] inst,
	input  logic [data_w-1:0] x,
	input  logic [data_w-1:0] y,
	input  logic [data_w-1:0] dread_data,
	output logic [1:0]        wr_addr,
	output logic [1:0]        wr_en,
	output logic [data_w-1:0] wr_data,
	output flags_t            next_flags,
	output logic [addr_w-1:0] dwrite_addr,
	output logic [data_w-1:0] dwrite_data,
	output logic [1:0]        dwrite_en,
	output logic              trap
);
	flags_t flags;
	flags_t alu_flags;
	logic [data_w-1:0] operand;
	logic [data_w-1:0] result;

	always_comb
	begin
		case (ctrl.src)
			src_y:
				operand = y;
			src_imm8:
				operand = {8'h00, inst[15:8]};
			src_imm16:
				operand = inst[23:8];
			src_dread8:
				operand = {8'h00, dread_data[7:0]};
			default:
				operand = {8'h00, x[7:0]};
		endcase
	end

	// accumulator is always xl
	cpu_alu u_alu (
		.op       (ctrl.alu_op),
		.a        (x),
		.b        (operand),
		.result   (result),
		.flags_out(alu_flags)
	);

	assign next_flags = (alu_flags & ctrl.flag_mask) | (flags & ~ctrl.flag_mask);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	assign wr_addr = ctrl.wr_addr;
	assign wr_en = ctrl.wr_en;
	assign wr_data = ctrl.to_high ? {result[7:0], result[7:0]} : result;

	// stores only use direct addressing
	assign dwrite_addr = inst[23:8];
	assign dwrite_en = ctrl.dw_en;
	assign dwrite_data = (ctrl.st_src == st_y) ? y :
		(ctrl.st_src == st_x) ? x : {8'h00, x[7:0]};

	assign trap = ctrl.trap;

endmodule

// File: verilog/cpu_decode.sv
module cpu_decode
	import cpu_pkg::*;
(
	input  opcode_t    inst_opcode,
	input  logic       exec_valid,
	output exec_ctrl_t ctrl
);

	always_comb
	begin
		ctrl = '0;
		ctrl.wr_addr = reg_x;
		ctrl.flag_mask = fl_none;
		if (exec_valid)
		begin
			case (inst_opcode)
				op_ld_xl_imm, op_add_xl_imm, op_sub_xl_imm, op_and_xl_imm,
				op_or_xl_imm, op_xor_xl_imm:
				begin
					ctrl.src = src_imm8;
					ctrl.wr_en = 2'b01;
					ctrl.flag_mask = fl_zn;
					case (inst_opcode)
						op_add_xl_imm:
						begin
							ctrl.alu_op = alu_add;
							ctrl.flag_mask = fl_czn;
						end
						op_sub_xl_imm:
						begin
							ctrl.alu_op = alu_sub;
							ctrl.flag_mask = fl_czn;
						end
						op_and_xl_imm:
							ctrl.alu_op = alu_and;
						op_or_xl_imm:
							ctrl.alu_op = alu_or;
						op_xor_xl_imm:
							ctrl.alu_op = alu_xor;
						default:
							ctrl.alu_op = alu_pass8;
					endcase
				end
				op_add_xl_dir:
				begin
					ctrl.alu_op = alu_add;
					ctrl.src = src_dread8;
					ctrl.wr_en = 2'b01;
					ctrl.flag_mask = fl_czn;
				end
				op_ld_xl_yrel:
				begin
					ctrl.src = src_dread8;
					ctrl.wr_en = 2'b01;
					ctrl.flag_mask = fl_zn;
				end
				op_inc_xl:
				begin
					ctrl.alu_op = alu_inc;
					ctrl.wr_en = 2'b01;
					ctrl.flag_mask = fl_czn;
				end
				op_ld_xh_xl:
				begin
					ctrl.wr_en = 2'b10;
					ctrl.to_high = 1'b1;
				end
				op_ldw_y_imm, op_ldw_z_y:
				begin
					ctrl.alu_op = alu_pass16;
					ctrl.src = (inst_opcode == op_ldw_z_y) ? src_y : src_imm16;
					ctrl.wr_addr = (inst_opcode == op_ldw_z_y) ? reg_z : reg_y;
					ctrl.wr_en = 2'b11;
					ctrl.flag_mask = fl_zn;
				end
				op_incw_y:
				begin
					ctrl.alu_op = alu_incw;
					ctrl.src = src_y;
					ctrl.wr_addr = reg_y;
					ctrl.wr_en = 2'b11;
					ctrl.flag_mask = fl_czn;
				end
				op_ld_dir_xl:
				begin
					ctrl.dw_en = 2'b01;
					ctrl.st_src = st_xl;
				end
				op_ldw_dir_x, op_ldw_dir_y:
				begin
					ctrl.dw_en = 2'b11;
					ctrl.st_src = (inst_opcode == op_ldw_dir_y) ? st_y : st_x;
				end
				op_trap:
					ctrl.trap = 1'b1;
				// jumps are handled in fetch
				default:
					ctrl.wr_en = 2'b00;
			endcase
		end
	end

endmodule

// File: verilog/cpu_fetch.sv
module cpu_fetch
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [inst_w-1:0] iread_data,
	input  flags_t            next_flags,
	input  logic [data_w-1:0] next_y,
	output logic [addr_w-1:0] iread_addr,
	output logic [addr_w-1:0] dread_addr,
	output logic [inst_w-1:0] inst,
	output logic              exec_valid
);
	opcode_t fop;
	logic [7:0] disp;
	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] next_pc;
	logic fetch_valid;
	logic taken;

	// pc is the address of the instruction now on iread_data
	assign fop = opcode_t'(iread_data[7:0]);
	assign disp = iread_data[15:8];

	always_comb
	begin
		case (fop)
			op_jrz:
				taken = next_flags.z;
			op_jrnz:
				taken = !next_flags.z;
			op_jrc:
				taken = next_flags.c;
			op_jrnc:
				taken = !next_flags.c;
			default:
				taken = 1'b0;
		endcase

		// hold at the reset vector until its word is on iread_data
		if (!fetch_valid)
			next_pc = pc;
		else if (fop == op_jp)
			next_pc = iread_data[23:8];
		else if (taken)
			next_pc = pc + {{8{disp[7]}}, disp};
		else
			next_pc = pc + {{(addr_w-2){1'b0}}, insn_length(fop)};
	end

	assign iread_addr = next_pc;
	assign dread_addr = (fop == op_ld_xl_yrel) ? next_y + {8'h00, disp} : iread_data[23:8];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= reset_vector;
			fetch_valid <= 1'b0;
			exec_valid <= 1'b0;
		end
		else
		begin
			pc <= next_pc;
			fetch_valid <= 1'b1;
			exec_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		inst <= iread_data;
	end

endmodule

// File: verilog/cpu_alu.sv
module cpu_alu
	import cpu_pkg::*;
(
	input  alu_op_t           op,
	input  logic [data_w-1:0] a,
	input  logic [data_w-1:0] b,
	output logic [data_w-1:0] result,
	output flags_t            flags_out
);
	logic [16:0] sum;
	logic carry;
	logic wide;

	// binary ops take a as the accumulator, unary ops work on b
	always_comb
	begin
		sum = 17'd0;
		carry = 1'b0;
		wide = 1'b0;
		result = {8'h00, b[7:0]};
		case (op)
			alu_pass16:
			begin
				result = b;
				wide = 1'b1;
			end
			alu_add:
			begin
				sum = {9'd0, a[7:0]} + {9'd0, b[7:0]};
				result = {8'h00, sum[7:0]};
				carry = sum[8];
			end
			alu_sub:
			begin
				sum = {9'd0, a[7:0]} - {9'd0, b[7:0]};
				result = {8'h00, sum[7:0]};
				// borrow
				carry = sum[8];
			end
			alu_and:
				result = {8'h00, a[7:0] & b[7:0]};
			alu_or:
				result = {8'h00, a[7:0] | b[7:0]};
			alu_xor:
				result = {8'h00, a[7:0] ^ b[7:0]};
			alu_inc:
			begin
				sum = {9'd0, b[7:0]} + 17'd1;
				result = {8'h00, sum[7:0]};
				carry = sum[8];
			end
			alu_incw:
			begin
				sum = {1'b0, b} + 17'd1;
				result = sum[15:0];
				carry = sum[16];
				wide = 1'b1;
			end
			default:
				result = {8'h00, b[7:0]};
		endcase
		flags_out.c = carry;
		flags_out.z = wide ? (result == 16'h0000) : (result[7:0] == 8'h00);
		flags_out.n = wide ? result[15] : result[7];
	end

endmodule

// File: verilog/cpu_regfile.sv
module cpu_regfile
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic [1:0]        wr_addr,
	input  logic [data_w-1:0] wr_data,
	input  logic [1:0]        wr_en,
	output logic [data_w-1:0] x,
	output logic [data_w-1:0] y,
	output logic [data_w-1:0] z,
	output logic [data_w-1:0] next_y
);
	logic [data_w-1:0] regs [3];

	assign x = regs[reg_x];
	assign y = regs[reg_y];
	assign z = regs[reg_z];

	// next value of y feeds the fetch address adder
	assign next_y[15:8] = (wr_addr == reg_y && wr_en[1]) ? wr_data[15:8] : regs[reg_y][15:8];
	assign next_y[7:0] = (wr_addr == reg_y && wr_en[0]) ? wr_data[7:0] : regs[reg_y][7:0];

	always_ff @(posedge clk)
	begin
		if (wr_en[0])
			regs[wr_addr][7:0] <= wr_data[7:0];
		if (wr_en[1])
			regs[wr_addr][15:8] <= wr_data[15:8];
	end

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

	localparam int data_w = 16;
	localparam int addr_w = 16;
	localparam int inst_w = 24;

	localparam logic [addr_w-1:0] reset_vector = 16'h4000;

	localparam logic [1:0] reg_x = 2'd0;
	localparam logic [1:0] reg_y = 2'd1;
	localparam logic [1:0] reg_z = 2'd2;

	// unlisted values execute as nop
	typedef enum logic [7:0] {
		op_nop       = 8'h00,
		op_trap      = 8'h01,
		op_ld_xl_imm = 8'h10,
		op_add_xl_imm = 8'h11,
		op_sub_xl_imm = 8'h12,
		op_and_xl_imm = 8'h13,
		op_or_xl_imm = 8'h14,
		op_xor_xl_imm = 8'h15,
		op_add_xl_dir = 8'h16,
		op_ld_xl_yrel = 8'h17,
		op_inc_xl    = 8'h18,
		op_ld_xh_xl  = 8'h19,
		op_ldw_y_imm = 8'h1a,
		op_ldw_z_y   = 8'h1b,
		op_incw_y    = 8'h1c,
		op_ld_dir_xl = 8'h20,
		op_ldw_dir_x = 8'h21,
		op_ldw_dir_y = 8'h22,
		op_jp        = 8'h30,
		op_jrz       = 8'h31,
		op_jrnz      = 8'h32,
		op_jrc       = 8'h33,
		op_jrnc      = 8'h34
	} opcode_t;

	typedef enum logic [3:0] {
		alu_pass8,
		alu_pass16,
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_inc,
		alu_incw
	} alu_op_t;

	typedef enum logic [2:0] {
		src_xl,
		src_y,
		src_imm8,
		src_imm16,
		src_dread8
	} src_t;

	typedef enum logic [1:0] {
		st_xl,
		st_x,
		st_y
	} store_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	localparam flags_t fl_none = 3'b000;
	localparam flags_t fl_zn = 3'b011;
	localparam flags_t fl_czn = 3'b111;

	typedef struct packed {
		alu_op_t alu_op;
		src_t src;
		logic [1:0] wr_addr;
		logic [1:0] wr_en;
		logic to_high;
		logic [1:0] dw_en;
		store_t st_src;
		flags_t flag_mask;
		logic trap;
	} exec_ctrl_t;

	function automatic logic [1:0] insn_length(opcode_t op);
		case (op)
			op_ld_xl_imm, op_add_xl_imm, op_sub_xl_imm, op_and_xl_imm,
			op_or_xl_imm, op_xor_xl_imm, op_ld_xl_yrel,
			op_jrz, op_jrnz, op_jrc, op_jrnc:
				insn_length = 2'd2;
			op_ldw_y_imm, op_add_xl_dir, op_ld_dir_xl, op_ldw_dir_x,
			op_ldw_dir_y, op_jp:
				insn_length = 2'd3;
			default:
				insn_length = 2'd1;
		endcase
	endfunction

endpackage
